// ==== compile.f ====
verilog/movegen_pkg.sv
verilog/board_decoder.sv
verilog/king_attacks.sv
verilog/knight_attacks.sv
verilog/rook_attacks.sv
verilog/bishop_attacks.sv
verilog/piece_scanner.sv
verilog/move_arbiter.sv
verilog/move_generator.sv
verif/move_generator_assertions.sv
verif/move_generator_tb.sv

// ==== verif/move_generator_assertions.sv ====
`timescale 1ns/100ps

module move_generator_assertions (
    input logic                 clk_in,
    input logic                 rst_in,
    input logic                 valid_in,
    input logic                 ready_out,
    input logic                 valid_out,
    input movegen_pkg::square_t move_src,
    input movegen_pkg::square_t move_dst
);

    int fail_count = 0;

    // outputs settle to idle one cycle after reset is seen
    reset_idle: assert property (@(posedge clk_in) rst_in |=> (!valid_out && ready_out))
        else begin
            fail_count++;
            $error("outputs not idle after reset");
        end

    accept_busy: assert property (@(posedge clk_in) disable iff (rst_in)
        (valid_in && ready_out) |=> !ready_out)
        else begin
            fail_count++;
            $error("ready_out still high after an accepted valid_in");
        end

    // a piece never moves onto its own square
    distinct_squares: assert property (@(posedge clk_in) disable iff (rst_in)
        valid_out |-> (move_dst != move_src))
        else begin
            fail_count++;
            $error("move with equal source and destination");
        end

endmodule

bind move_generator move_generator_assertions checks (.*);

// ==== verif/move_generator_tb.sv ====
`timescale 1ns/100ps

module move_generator_tb;

    localparam int CLK_PERIOD = 20;
    localparam int NUM_RANDOM = 20;
    localparam int NUM_BOARDS = NUM_RANDOM + 5;

    logic clk_in;
    logic rst_in;
    logic valid_in;
    logic black_to_move;
    logic [63:0] pawns, knights, bishops, rooks, queens, white;
    logic [5:0] white_king;
    logic [5:0] black_king;
    logic [5:0] move_src;
    logic [5:0] move_dst;
    logic valid_out;
    logic ready_out;

    // one bit per source and destination pair, src * 64 + dst
    logic [4095:0] expect_set;
    logic [4095:0] seen;
    logic [63:0] used;
    int received;
    int errors;
    int total_moves;
    integer seed;
    string test_name;

    move_generator uut (.*);

    initial clk_in = 1'b0;
    always #(CLK_PERIOD / 2) clk_in = ~clk_in;

    // destinations along one direction, up to and including the first enemy piece
    function automatic logic [63:0] walk_ray(input int sq, input int dr, input int df,
                                             input int max_steps, input logic [63:0] occ,
                                             input logic [63:0] own);
        logic [63:0] dst;
        int r;
        int f;
        int steps;
        dst = '0;
        r = sq / 8 + dr;
        f = sq % 8 + df;
        steps = 0;
        while (r >= 0 && r < 8 && f >= 0 && f < 8 && steps < max_steps) begin
            if (own[r*8 + f]) begin
                break;
            end
            dst[r*8 + f] = 1'b1;
            if (occ[r*8 + f]) begin
                break;
            end
            r += dr;
            f += df;
            steps++;
        end
        return dst;
    endfunction

    function automatic logic [4095:0] expected_moves(
        input logic [63:0] pawns_b,
        input logic [63:0] knights_b,
        input logic [63:0] bishops_b,
        input logic [63:0] rooks_b,
        input logic [63:0] queens_b,
        input logic [63:0] white_b,
        input logic [5:0] wk,
        input logic [5:0] bk,
        input logic btm
    );
        logic [4095:0] moves;
        logic [63:0] occ;
        logic [63:0] own;
        logic [63:0] dst;
        int own_king;
        occ = pawns_b | knights_b | bishops_b | rooks_b | queens_b;
        own = occ & (btm ? ~white_b : white_b);
        occ[wk] = 1'b1;
        occ[bk] = 1'b1;
        own_king = btm ? bk : wk;
        own[own_king] = 1'b1;
        moves = '0;
        for (int s = 0; s < 64; s++) begin
            dst = '0;
            for (int dr = -2; dr <= 2; dr++) begin
                for (int df = -2; df <= 2; df++) begin
                    if (s == own_king && dr*dr <= 1 && df*df <= 1 && (dr != 0 || df != 0)) begin
                        dst |= walk_ray(s, dr, df, 1, occ, own);
                    end
                    if (knights_b[s] && own[s] && dr*dr + df*df == 5) begin
                        dst |= walk_ray(s, dr, df, 1, occ, own);
                    end
                    if ((bishops_b[s] || queens_b[s]) && own[s] && dr*dr == 1 && df*df == 1) begin
                        dst |= walk_ray(s, dr, df, 7, occ, own);
                    end
                    if ((rooks_b[s] || queens_b[s]) && own[s] && dr*dr + df*df == 1) begin
                        dst |= walk_ray(s, dr, df, 7, occ, own);
                    end
                end
            end
            moves[s*64 +: 64] = dst;
        end
        return moves;
    endfunction

    task automatic check_value(input string name, input int expected, input int actual);
        if (expected != actual) begin
            $display("[FAIL] %s: expected %0d, actual %0d", name, expected, actual);
            errors++;
        end
    endtask

    // every move is recorded, outside a board the expected set is empty
    always @(negedge clk_in) begin
        int idx;
        if (!rst_in && valid_out) begin
            idx = move_src * 64 + move_dst;
            if (seen[idx]) begin
                $display("error in %s: move %0d to %0d was sent twice", test_name,
                         move_src, move_dst);
                errors++;
            end
            if (!expect_set[idx]) begin
                $display("error in %s: move %0d to %0d should not exist", test_name,
                         move_src, move_dst);
                errors++;
            end
            seen[idx] = 1'b1;
            received++;
        end
    end

    task automatic clear_board();
        @(posedge clk_in);
        #1;
        pawns = '0;
        knights = '0;
        bishops = '0;
        rooks = '0;
        queens = '0;
        white = '0;
        white_king = '0;
        black_king = '0;
        black_to_move = 1'b0;
    endtask

    task automatic set_start_position();
        clear_board();
        pawns = 64'h00ff_0000_0000_ff00;
        knights = 64'h4200_0000_0000_0042;
        bishops = 64'h2400_0000_0000_0024;
        rooks = 64'h8100_0000_0000_0081;
        queens = 64'h0800_0000_0000_0008;
        white = 64'h0000_0000_0000_ffff;
        white_king = 6'd4;
        black_king = 6'd60;
    endtask

    // white king on h3 next to its own pawn, black king in the a8 corner
    task automatic set_open_position(input logic side);
        clear_board();
        pawns = (64'd1 << 11) | (64'd1 << 31) | (64'd1 << 38);
        knights = 64'd1 << 45;
        bishops = (64'd1 << 9) | (64'd1 << 47);
        rooks = (64'd1 << 27) | (64'd1 << 51);
        queens = (64'd1 << 36) | (64'd1 << 41);
        white = (64'd1 << 9) | (64'd1 << 27) | (64'd1 << 31) | (64'd1 << 36) | (64'd1 << 38);
        white_king = 6'd23;
        black_king = 6'd56;
        black_to_move = side;
    endtask

    task automatic pick_square(output int sq);
        do begin
            sq = $unsigned($random(seed)) % 64;
        end while (used[sq]);
        used[sq] = 1'b1;
    endtask

    task automatic set_random_position();
        int sq;
        int count;
        logic [31:0] rnd;
        clear_board();
        used = '0;
        pick_square(sq);
        white_king = 6'(sq);
        pick_square(sq);
        black_king = 6'(sq);
        rnd = $random(seed);
        black_to_move = rnd[0];
        count = 4 + $unsigned($random(seed)) % 14;
        for (int i = 0; i < count; i++) begin
            pick_square(sq);
            rnd = $random(seed);
            white[sq] = rnd[8];
            case (rnd[2:0] % 5)
                0: pawns[sq] = 1'b1;
                1: knights[sq] = 1'b1;
                2: bishops[sq] = 1'b1;
                3: rooks[sq] = 1'b1;
                default: queens[sq] = 1'b1;
            endcase
        end
    endtask

    // board inputs are already set 1 ns after an edge with ready_out high
    task automatic run_board(input string name, input logic extra_pulse);
        test_name = name;
        expect_set = expected_moves(pawns, knights, bishops, rooks, queens, white,
                                    white_king, black_king, black_to_move);
        seen = '0;
        received = 0;
        valid_in = 1'b1;
        @(posedge clk_in);
        #1;
        if (extra_pulse) begin
            // new board offered while the first one is still running
            queens = queens | (64'd1 << 27);
            white = white | (64'd1 << 27);
        end else begin
            valid_in = 1'b0;
        end
        @(negedge clk_in);
        check_value({name, " ready_out after accept"}, 0, ready_out);
        if (extra_pulse) begin
            @(posedge clk_in);
            #1;
            valid_in = 1'b0;
        end
        while (!ready_out) begin
            @(negedge clk_in);
        end
        check_value({name, " move count"}, $countones(expect_set), received);
        total_moves += received;
        expect_set = '0;
    endtask

    initial begin
        seed = 32'h477a;
        errors = 0;
        total_moves = 0;
        received = 0;
        expect_set = '0;
        seen = '0;
        used = '0;
        test_name = "reset";
        rst_in = 1'b1;
        valid_in = 1'b0;
        black_to_move = 1'b0;
        pawns = '0;
        knights = '0;
        bishops = '0;
        rooks = '0;
        queens = '0;
        white = '0;
        white_king = '0;
        black_king = '0;
        repeat (2) @(posedge clk_in);
        #1;
        rst_in = 1'b0;
        repeat (4) @(negedge clk_in);
        check_value("reset ready_out", 1, ready_out);
        check_value("reset idle moves", 0, received);

        set_start_position();
        run_board("start position", 1'b0);
        check_value("start position knight moves", 4, received);

        set_open_position(1'b0);
        run_board("open board white", 1'b0);
        set_open_position(1'b1);
        run_board("open board black", 1'b0);

        for (int i = 0; i < NUM_RANDOM; i++) begin
            set_random_position();
            run_board($sformatf("random board %0d", i), 1'b0);
        end

        set_start_position();
        run_board("ignored valid_in", 1'b1);
        check_value("ignored valid_in moves", 4, received);

        $display("errors: %0d, assertion failures: %0d, moves checked: %0d", errors,
                 uut.checks.fail_count, total_moves);
        if (errors == 0 && uut.checks.fail_count == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

    initial begin
        #(NUM_BOARDS * 400 * CLK_PERIOD);
        $display("timeout: ready_out never returned high during %s", test_name);
        $display("SIMULATION FAILED");
        $finish;
    end

endmodule

// ==== verilog/bishop_attacks.sv ====
`timescale 1ns/100ps

module bishop_attacks (
    input  movegen_pkg::square_t   sq,
    input  movegen_pkg::bitboard_t occupied,
    output movegen_pkg::bitboard_t attacks
);
    import movegen_pkg::*;

    always_comb begin
        logic [2:0] rank_idx;
        logic [2:0] file_idx;
        logic [3:0] rank_sum;
        bitboard_t src_bit;
        bitboard_t diag_mask;
        bitboard_t anti_mask;
        bitboard_t diag_occ;
        bitboard_t anti_occ;
        bitboard_t up_diag;
        bitboard_t down_diag;
        bitboard_t up_anti;
        bitboard_t down_anti;

        rank_idx = sq[5:3];
        file_idx = sq[2:0];
        rank_sum = {1'b0, rank_idx} + {1'b0, file_idx};
        src_bit = bitboard_t'(1) << sq;

        // move the base lines up or down by whole ranks
        if (rank_idx >= file_idx) begin
            diag_mask = DIAG_PATTERN << {rank_idx - file_idx, 3'b000};
        end else begin
            diag_mask = DIAG_PATTERN >> {file_idx - rank_idx, 3'b000};
        end
        if (rank_sum >= 4'd7) begin
            anti_mask = ANTIDIAG_PATTERN << {rank_sum - 4'd7, 3'b000};
        end else begin
            anti_mask = ANTIDIAG_PATTERN >> {4'd7 - rank_sum, 3'b000};
        end

        diag_occ = occupied & diag_mask & ~src_bit;
        anti_occ = occupied & anti_mask & ~src_bit;

        // one square per rank on a diagonal, so a byte swap reverses the line
        up_diag = diag_occ - src_bit;
        down_diag = swap_ranks(swap_ranks(diag_occ) - swap_ranks(src_bit));
        up_anti = anti_occ - src_bit;
        down_anti = swap_ranks(swap_ranks(anti_occ) - swap_ranks(src_bit));

        attacks = ((up_diag ^ down_diag) & diag_mask) | ((up_anti ^ down_anti) & anti_mask);
    end

endmodule

// ==== verilog/board_decoder.sv ====
`timescale 1ns/100ps

module board_decoder (
    input  logic                   clk_in,
    input  logic                   rst_in,
    input  logic                   valid_in,
    input  logic                   ready_in,
    input  logic                   black_to_move,
    input  movegen_pkg::bitboard_t pawns,
    input  movegen_pkg::bitboard_t knights,
    input  movegen_pkg::bitboard_t bishops,
    input  movegen_pkg::bitboard_t rooks,
    input  movegen_pkg::bitboard_t queens,
    input  movegen_pkg::bitboard_t white,
    input  movegen_pkg::square_t   white_king,
    input  movegen_pkg::square_t   black_king,
    output logic                   load,
    output movegen_pkg::bitboard_t occupied,
    output movegen_pkg::bitboard_t own,
    output movegen_pkg::bitboard_t king_set,
    output movegen_pkg::bitboard_t knight_set,
    output movegen_pkg::bitboard_t diag_set,
    output movegen_pkg::bitboard_t orth_set
);
    import movegen_pkg::*;

    logic accept;
    bitboard_t pieces;
    bitboard_t side_mask;
    bitboard_t own_king;
    bitboard_t own_next;

    assign accept = valid_in && ready_in;

    // kings travel as squares, so they are added separately
    assign pieces = pawns | knights | bishops | rooks | queens;
    assign side_mask = black_to_move ? ~white : white;
    assign own_king = bitboard_t'(1) << (black_to_move ? black_king : white_king);
    assign own_next = (pieces & side_mask) | own_king;

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            load <= 1'b0;
        end else begin
            load <= accept;
        end
    end

    always_ff @(posedge clk_in) begin
        if (accept) begin
            occupied <= pieces | (bitboard_t'(1) << white_king) | (bitboard_t'(1) << black_king);
            own <= own_next;
            king_set <= own_king;
            knight_set <= knights & own_next;
            diag_set <= (bishops | queens) & own_next;
            orth_set <= (rooks | queens) & own_next;
        end
    end

endmodule

// ==== verilog/king_attacks.sv ====
`timescale 1ns/100ps

module king_attacks (
    input  movegen_pkg::square_t   sq,
    output movegen_pkg::bitboard_t attacks
);
    import movegen_pkg::*;

    logic [6:0] shift;
    logic [PAD_KING*PAD_KING-1:0] padded;

    // one guard column and row on every side
    assign shift = 7'(sq[5:3]) * 7'(PAD_KING) + 7'(sq[2:0]);
    assign padded = KING_PATTERN << shift;

    for (genvar r = 0; r < 8; r++) begin : g_rank
        assign attacks[r*8 +: 8] = padded[r*PAD_KING + PAD_KING + 1 +: 8];
    end

endmodule

// ==== verilog/knight_attacks.sv ====
`timescale 1ns/100ps

module knight_attacks (
    input  movegen_pkg::square_t   sq,
    output movegen_pkg::bitboard_t attacks
);
    import movegen_pkg::*;

    logic [6:0] shift;
    logic [PAD_KNIGHT*PAD_KNIGHT-1:0] padded;

    // two guard columns and rows on every side, enough for the long jump
    assign shift = 7'(sq[5:3]) * 7'(PAD_KNIGHT) + 7'(sq[2:0]);
    assign padded = KNIGHT_PATTERN << shift;

    // guard columns are dropped here, which removes any wrapped jump
    for (genvar r = 0; r < 8; r++) begin : g_rank
        assign attacks[r*8 +: 8] = padded[r*PAD_KNIGHT + 2*PAD_KNIGHT + 2 +: 8];
    end

endmodule

// ==== verilog/move_arbiter.sv ====
`timescale 1ns/100ps

module move_arbiter (
    input  logic                 clk_in,
    input  logic                 rst_in,
    input  logic                 load,
    input  logic                 king_cand_valid,
    input  movegen_pkg::square_t king_cand_src,
    input  movegen_pkg::square_t king_cand_dst,
    input  logic                 king_busy,
    input  logic                 knight_cand_valid,
    input  movegen_pkg::square_t knight_cand_src,
    input  movegen_pkg::square_t knight_cand_dst,
    input  logic                 knight_busy,
    input  logic                 diag_cand_valid,
    input  movegen_pkg::square_t diag_cand_src,
    input  movegen_pkg::square_t diag_cand_dst,
    input  logic                 diag_busy,
    input  logic                 orth_cand_valid,
    input  movegen_pkg::square_t orth_cand_src,
    input  movegen_pkg::square_t orth_cand_dst,
    input  logic                 orth_busy,
    output logic                 king_take,
    output logic                 knight_take,
    output logic                 diag_take,
    output logic                 orth_take,
    output movegen_pkg::square_t move_src,
    output movegen_pkg::square_t move_dst,
    output logic                 valid_out,
    output logic                 ready_out
);

    // fixed priority, king first
    assign king_take = king_cand_valid;
    assign knight_take = knight_cand_valid && !king_cand_valid;
    assign diag_take = diag_cand_valid && !king_cand_valid && !knight_cand_valid;
    assign orth_take = orth_cand_valid && !king_cand_valid && !knight_cand_valid
                       && !diag_cand_valid;

    // stays low until the last move has left the output register
    assign ready_out = !(load || king_busy || knight_busy || diag_busy || orth_busy
                         || valid_out);

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            valid_out <= 1'b0;
        end else begin
            valid_out <= king_take || knight_take || diag_take || orth_take;
        end
    end

    always_ff @(posedge clk_in) begin
        if (king_take) begin
            move_src <= king_cand_src;
            move_dst <= king_cand_dst;
        end else if (knight_take) begin
            move_src <= knight_cand_src;
            move_dst <= knight_cand_dst;
        end else if (diag_take) begin
            move_src <= diag_cand_src;
            move_dst <= diag_cand_dst;
        end else if (orth_take) begin
            move_src <= orth_cand_src;
            move_dst <= orth_cand_dst;
        end
    end

endmodule

// ==== verilog/move_generator.sv ====
`timescale 1ns/100ps

module move_generator (
    input  logic                   clk_in,
    input  logic                   rst_in,
    input  logic                   valid_in,
    input  logic                   black_to_move,
    input  movegen_pkg::bitboard_t pawns,
    input  movegen_pkg::bitboard_t knights,
    input  movegen_pkg::bitboard_t bishops,
    input  movegen_pkg::bitboard_t rooks,
    input  movegen_pkg::bitboard_t queens,
    input  movegen_pkg::bitboard_t white,
    input  movegen_pkg::square_t   white_king,
    input  movegen_pkg::square_t   black_king,
    output movegen_pkg::square_t   move_src,
    output movegen_pkg::square_t   move_dst,
    output logic                   valid_out,
    output logic                   ready_out
);
    import movegen_pkg::*;

    logic load;
    bitboard_t occupied;
    bitboard_t own;
    bitboard_t king_set;
    bitboard_t knight_set;
    bitboard_t diag_set;
    bitboard_t orth_set;

    // per class: source to the attack unit, mask back, candidate to the arbiter
    square_t king_src, knight_src, diag_src, orth_src;
    bitboard_t king_mask, knight_mask, diag_mask, orth_mask;
    logic king_cand_valid, knight_cand_valid, diag_cand_valid, orth_cand_valid;
    square_t king_cand_src, knight_cand_src, diag_cand_src, orth_cand_src;
    square_t king_cand_dst, knight_cand_dst, diag_cand_dst, orth_cand_dst;
    logic king_busy, knight_busy, diag_busy, orth_busy;
    logic king_take, knight_take, diag_take, orth_take;

    board_decoder decoder (
        .clk_in(clk_in), .rst_in(rst_in), .valid_in(valid_in), .ready_in(ready_out),
        .black_to_move(black_to_move), .pawns(pawns), .knights(knights),
        .bishops(bishops), .rooks(rooks), .queens(queens), .white(white),
        .white_king(white_king), .black_king(black_king), .load(load),
        .occupied(occupied), .own(own), .king_set(king_set), .knight_set(knight_set),
        .diag_set(diag_set), .orth_set(orth_set)
    );

    king_attacks king_unit (.sq(king_src), .attacks(king_mask));
    knight_attacks knight_unit (.sq(knight_src), .attacks(knight_mask));
    bishop_attacks diag_unit (.sq(diag_src), .occupied(occupied), .attacks(diag_mask));
    rook_attacks orth_unit (.sq(orth_src), .occupied(occupied), .attacks(orth_mask));

    piece_scanner king_scan (
        .clk_in(clk_in), .rst_in(rst_in), .load(load), .take(king_take),
        .sources(king_set), .own(own), .attacks(king_mask), .src(king_src),
        .cand_src(king_cand_src), .cand_dst(king_cand_dst),
        .cand_valid(king_cand_valid), .busy(king_busy)
    );

    piece_scanner knight_scan (
        .clk_in(clk_in), .rst_in(rst_in), .load(load), .take(knight_take),
        .sources(knight_set), .own(own), .attacks(knight_mask), .src(knight_src),
        .cand_src(knight_cand_src), .cand_dst(knight_cand_dst),
        .cand_valid(knight_cand_valid), .busy(knight_busy)
    );

    piece_scanner diag_scan (
        .clk_in(clk_in), .rst_in(rst_in), .load(load), .take(diag_take),
        .sources(diag_set), .own(own), .attacks(diag_mask), .src(diag_src),
        .cand_src(diag_cand_src), .cand_dst(diag_cand_dst),
        .cand_valid(diag_cand_valid), .busy(diag_busy)
    );

    piece_scanner orth_scan (
        .clk_in(clk_in), .rst_in(rst_in), .load(load), .take(orth_take),
        .sources(orth_set), .own(own), .attacks(orth_mask), .src(orth_src),
        .cand_src(orth_cand_src), .cand_dst(orth_cand_dst),
        .cand_valid(orth_cand_valid), .busy(orth_busy)
    );

    move_arbiter arbiter (
        .clk_in(clk_in), .rst_in(rst_in), .load(load),
        .king_cand_valid(king_cand_valid), .king_cand_src(king_cand_src),
        .king_cand_dst(king_cand_dst), .king_busy(king_busy),
        .knight_cand_valid(knight_cand_valid), .knight_cand_src(knight_cand_src),
        .knight_cand_dst(knight_cand_dst), .knight_busy(knight_busy),
        .diag_cand_valid(diag_cand_valid), .diag_cand_src(diag_cand_src),
        .diag_cand_dst(diag_cand_dst), .diag_busy(diag_busy),
        .orth_cand_valid(orth_cand_valid), .orth_cand_src(orth_cand_src),
        .orth_cand_dst(orth_cand_dst), .orth_busy(orth_busy),
        .king_take(king_take), .knight_take(knight_take), .diag_take(diag_take),
        .orth_take(orth_take), .move_src(move_src), .move_dst(move_dst),
        .valid_out(valid_out), .ready_out(ready_out)
    );

endmodule

// ==== verilog/movegen_pkg.sv ====
package movegen_pkg;

    typedef logic [5:0] square_t;
    typedef logic [63:0] bitboard_t;
    typedef logic [7:0] rank_t;

    typedef enum logic [1:0] {
        SCAN_IDLE,
        SCAN_FETCH,
        SCAN_EMIT
    } scan_state_t;

    localparam int BOARD_SQUARES = 64;

    // step patterns centred on the origin square of a padded board
    localparam int PAD_KING = 10;
    localparam int PAD_KNIGHT = 12;
    localparam logic [PAD_KING*PAD_KING-1:0] KING_PATTERN = 100'h701407;
    localparam logic [PAD_KNIGHT*PAD_KNIGHT-1:0] KNIGHT_PATTERN = 144'ha01100001100a;

    // a1-h8 and h1-a8
    localparam bitboard_t DIAG_PATTERN = 64'h8040201008040201;
    localparam bitboard_t ANTIDIAG_PATTERN = 64'h0102040810204080;

    function automatic square_t lowest_square(input bitboard_t board);
        square_t idx;
        idx = '0;
        for (int i = BOARD_SQUARES - 1; i >= 0; i--) begin
            if (board[i]) begin
                idx = square_t'(i);
            end
        end
        return idx;
    endfunction

    function automatic bitboard_t clear_lowest(input bitboard_t board);
        return board & (board - bitboard_t'(1));
    endfunction

    function automatic rank_t reverse_rank(input rank_t line);
        rank_t flipped;
        for (int i = 0; i < 8; i++) begin
            flipped[i] = line[7-i];
        end
        return flipped;
    endfunction

    function automatic bitboard_t swap_ranks(input bitboard_t board);
        bitboard_t swapped;
        for (int i = 0; i < 8; i++) begin
            swapped[i*8 +: 8] = board[(7-i)*8 +: 8];
        end
        return swapped;
    endfunction

endpackage

// ==== verilog/piece_scanner.sv ====
`timescale 1ns/100ps

module piece_scanner (
    input  logic                   clk_in,
    input  logic                   rst_in,
    input  logic                   load,
    input  logic                   take,
    input  movegen_pkg::bitboard_t sources,
    input  movegen_pkg::bitboard_t own,
    input  movegen_pkg::bitboard_t attacks,
    output movegen_pkg::square_t   src,
    output movegen_pkg::square_t   cand_src,
    output movegen_pkg::square_t   cand_dst,
    output logic                   cand_valid,
    output logic                   busy
);
    import movegen_pkg::*;

    scan_state_t state;
    bitboard_t src_left;
    bitboard_t dst_left;
    bitboard_t src_next;
    logic last_dst;
    logic src_done;

    assign src = lowest_square(src_left);
    assign src_next = clear_lowest(src_left);
    assign last_dst = (clear_lowest(dst_left) == '0);

    // source finished when nothing is left to offer or the final one goes out
    assign src_done = (dst_left == '0) || (take && last_dst);

    assign cand_valid = (state == SCAN_EMIT) && (dst_left != '0);
    assign cand_src = src;
    assign cand_dst = lowest_square(dst_left);
    assign busy = (state != SCAN_IDLE);

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            state <= SCAN_IDLE;
            src_left <= '0;
            dst_left <= '0;
        end else if (load) begin
            src_left <= sources;
            state <= (sources != '0) ? SCAN_FETCH : SCAN_IDLE;
        end else begin
            case (state)
                SCAN_FETCH: begin
                    // attack unit sees the lowest source this cycle
                    dst_left <= attacks & ~own;
                    state <= SCAN_EMIT;
                end
                SCAN_EMIT: begin
                    if (src_done) begin
                        src_left <= src_next;
                        dst_left <= '0;
                        state <= (src_next != '0) ? SCAN_FETCH : SCAN_IDLE;
                    end else if (take) begin
                        dst_left <= clear_lowest(dst_left);
                    end
                end
                default: begin
                    state <= SCAN_IDLE;
                end
            endcase
        end
    end

endmodule

// ==== verilog/rook_attacks.sv ====
`timescale 1ns/100ps

module rook_attacks (
    input  movegen_pkg::square_t   sq,
    input  movegen_pkg::bitboard_t occupied,
    output movegen_pkg::bitboard_t attacks
);
    import movegen_pkg::*;

    always_comb begin
        bitboard_t others;
        rank_t rank_occ;
        rank_t file_occ;
        rank_t rank_bit;
        rank_t file_bit;
        rank_t east;
        rank_t west;
        rank_t north;
        rank_t south;
        rank_t rank_ray;
        rank_t file_ray;

        others = occupied & ~(bitboard_t'(1) << sq);

        rank_occ = others[sq[5:3]*8 +: 8];
        for (int i = 0; i < 8; i++) begin
            file_occ[i] = others[i*8 + sq[2:0]];
        end

        rank_bit = rank_t'(1) << sq[2:0];
        file_bit = rank_t'(1) << sq[5:3];

        // borrow runs up to and clears the first blocker
        east = rank_occ - rank_bit;
        west = reverse_rank(reverse_rank(rank_occ) - reverse_rank(rank_bit));
        north = file_occ - file_bit;
        south = reverse_rank(reverse_rank(file_occ) - reverse_rank(file_bit));

        // xor keeps both rays plus their blockers, source bit cancels
        rank_ray = east ^ west;
        file_ray = north ^ south;

        attacks = '0;
        for (int i = 0; i < 8; i++) begin
            attacks[sq[5:3]*8 + i] = attacks[sq[5:3]*8 + i] | rank_ray[i];
            attacks[i*8 + sq[2:0]] = attacks[i*8 + sq[2:0]] | file_ray[i];
        end
    end

endmodule
